//--- ex_slice_top.f
+incdir+source
source/ex_slice_pkg.sv
source/id_ctrl_if.sv
source/inst_decoder.sv
source/load_use_detector.sv
source/id_ex_reg.sv
source/ex_slice_top.sv
testbench/tb_ex_slice.sv

//--- Makefile
.PHONY: run clean

run: obj_dir/Vtb_ex_slice
	./obj_dir/Vtb_ex_slice | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

obj_dir/Vtb_ex_slice: ex_slice_top.f $(wildcard source/*.sv source/*.svh) testbench/tb_ex_slice.sv
	verilator --binary --timing --top-module tb_ex_slice -f ex_slice_top.f

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_ex_slice.sv
`default_nettype none
`timescale 1ns/100ps

`include "ex_slice_cfg.svh"

module tb_ex_slice;
    import ex_slice_pkg::*;

    localparam int RESET_LEN   = 4;
    localparam int DECODE_LEN  = 400;
    localparam int ILLEGAL_LEN = 200;
    localparam int LOAD_LEN    = 400;
    localparam int STALL_LEN   = 200;
    localparam int FLUSH_LEN   = 200;
    localparam int TIMEOUT     = RESET_LEN + DECODE_LEN + ILLEGAL_LEN + LOAD_LEN
                                 + STALL_LEN + FLUSH_LEN + 100;

    logic                clk;
    logic                rst_n;
    logic [`ILEN-1:0]    instr;
    logic [`XLEN-1:0]    pc;
    logic                instr_valid;
    logic                flush;
    logic                stall;
    logic                ex_valid;
    alu_op_e             ex_alu_op;
    sel_a_e              ex_sel_a;
    sel_b_e              ex_sel_b;
    wb_sel_e             ex_wb_sel;
    logic                ex_write_rd;
    logic                ex_mem_read;
    logic [7:0]          ex_mem_write_mask;
    logic [2:0]          ex_load_size;
    logic                ex_branch;
    logic                ex_jal;
    logic                ex_jalr;
    logic                ex_illegal;
    logic [`XLEN-1:0]    ex_imm;
    logic [`XLEN-1:0]    ex_pc;
    logic [`RADDR_W-1:0] ex_rs1;
    logic [`RADDR_W-1:0] ex_rs2;
    logic [`RADDR_W-1:0] ex_rd;
    logic                id_stall;

    ex_ctrl_t ex_model;   // expected content of the ID/EX register
    int       err_count;
    int       check_count;
    int       test_count;
    int       cycles;

    ex_slice_top u_dut (
        .clk                 (clk),
        .rst_n_i             (rst_n),
        .instr_i             (instr),
        .pc_i                (pc),
        .instr_valid_i       (instr_valid),
        .flush_i             (flush),
        .stall_i             (stall),
        .ex_valid_o          (ex_valid),
        .ex_alu_op_o         (ex_alu_op),
        .ex_sel_a_o          (ex_sel_a),
        .ex_sel_b_o          (ex_sel_b),
        .ex_wb_sel_o         (ex_wb_sel),
        .ex_write_rd_o       (ex_write_rd),
        .ex_mem_read_o       (ex_mem_read),
        .ex_mem_write_mask_o (ex_mem_write_mask),
        .ex_load_size_o      (ex_load_size),
        .ex_branch_o         (ex_branch),
        .ex_jal_o            (ex_jal),
        .ex_jalr_o           (ex_jalr),
        .ex_illegal_o        (ex_illegal),
        .ex_imm_o            (ex_imm),
        .ex_pc_o             (ex_pc),
        .ex_rs1_o            (ex_rs1),
        .ex_rs2_o            (ex_rs2),
        .ex_rd_o             (ex_rd),
        .id_stall_o          (id_stall)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        wait (cycles > TIMEOUT);
        $display("timeout: the run went past %0d cycles without finishing", TIMEOUT);
        $display("TEST FAILED");
        $finish;
    end

    // alt picks sub / sra for R-type and I-type ops
    function automatic alu_op_e reg_alu_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'd0:    op = alt ? ALU_SUB : ALU_ADD;
            3'd1:    op = ALU_SLL;
            3'd2:    op = ALU_SLT;
            3'd3:    op = ALU_SLTU;
            3'd4:    op = ALU_XOR;
            3'd5:    op = alt ? ALU_SRA : ALU_SRL;
            3'd6:    op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    function automatic alu_op_e word_alu_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        if (f3 == 3'd0) begin
            op = alt ? ALU_SUBW : ALU_ADDW;
        end else if (f3 == 3'd1) begin
            op = ALU_SLLW;
        end else begin
            op = alt ? ALU_SRAW : ALU_SRLW;
        end
        return op;
    endfunction

    function automatic ex_ctrl_t model_decode(input logic [31:0] w, input logic [63:0] pc_v,
                                              input logic v);
        ex_ctrl_t    e;
        logic        ok;
        logic        u1;
        logic        u2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [63:0] ii;
        logic [63:0] is;
        logic [63:0] ib;
        logic [63:0] iu;
        logic [63:0] ij;
        f3 = w[14:12];
        f7 = w[31:25];
        ii = 64'($signed(w[31:20]));
        is = 64'($signed({w[31:25], w[11:7]}));
        ib = 64'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        iu = 64'($signed({w[31:12], 12'h000}));
        ij = 64'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        e  = '0;
        ok = 1'b1;
        u1 = 1'b0;
        u2 = 1'b0;
        case (w[6:0])
            7'h33: begin   // op
                ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                u1 = 1'b1;
                u2 = 1'b1;
                e.write_rd = 1'b1;
                e.alu_op = reg_alu_op(f3, f7[5]);
            end
            7'h13: begin   // op-imm with a 6-bit shamt on rv64
                ok = !(f3 == 3'd1 && w[31:26] != 6'h00) &&
                     !(f3 == 3'd5 && w[31:26] != 6'h00 && w[31:26] != 6'h10);
                u1 = 1'b1;
                e.write_rd = 1'b1;
                e.sel_b = SEL_B_IMM;
                e.imm = ii;
                e.alu_op = reg_alu_op(f3, f3 == 3'd5 && w[30]);
            end
            7'h3b: begin
                ok = (f7 == 7'h00 && (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5)) ||
                     (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                u1 = 1'b1;
                u2 = 1'b1;
                e.write_rd = 1'b1;
                e.alu_op = word_alu_op(f3, f7[5]);
            end
            7'h1b: begin
                ok = (f3 == 3'd0) || (f3 == 3'd1 && f7 == 7'h00) ||
                     (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20));
                u1 = 1'b1;
                e.write_rd = 1'b1;
                e.sel_b = SEL_B_IMM;
                e.imm = ii;
                e.alu_op = word_alu_op(f3, f3 == 3'd5 && f7[5]);
            end
            7'h37: begin   // lui
                e.write_rd = 1'b1;
                e.alu_op = ALU_PASS_B;
                e.sel_a = SEL_A_ZERO;
                e.sel_b = SEL_B_IMM;
                e.imm = iu;
            end
            7'h17: begin
                e.write_rd = 1'b1;
                e.sel_a = SEL_A_PC;
                e.sel_b = SEL_B_IMM;
                e.imm = iu;
            end
            7'h6f, 7'h67: begin   // jal / jalr link pc+4
                ok = (w[6:0] == 7'h6f) || (f3 == 3'd0);
                u1 = (w[6:0] == 7'h67);
                e.write_rd = 1'b1;
                e.jal = (w[6:0] == 7'h6f);
                e.jalr = (w[6:0] == 7'h67);
                e.sel_a = SEL_A_PC;
                e.sel_b = SEL_B_FOUR;
                e.wb_sel = WB_PC4;
                e.imm = (w[6:0] == 7'h6f) ? ij : ii;
            end
            7'h63: begin
                ok = (f3 != 3'd2) && (f3 != 3'd3);
                u1 = 1'b1;
                u2 = 1'b1;
                e.branch = 1'b1;
                e.imm = ib;
                e.alu_op = !f3[2] ? ALU_SUB : (f3[1] ? ALU_SLTU : ALU_SLT);
            end
            7'h03: begin
                ok = (f3 != 3'd7);
                u1 = 1'b1;
                e.write_rd = 1'b1;
                e.mem_read = 1'b1;
                e.wb_sel = WB_MEM;
                e.sel_b = SEL_B_IMM;
                e.imm = ii;
                e.load_size = f3;
            end
            7'h23: begin   // byte mask of 1, 2, 4 or 8 bytes
                ok = !f3[2];
                u1 = 1'b1;
                u2 = 1'b1;
                e.sel_b = SEL_B_IMM;
                e.imm = is;
                e.mem_write_mask = 8'((16'h1 << (4'h1 << f3[1:0])) - 16'h1);
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            e = '0;
            u1 = 1'b0;
            u2 = 1'b0;
            e.illegal = 1'b1;
        end
        e.valid = 1'b1;
        e.pc = pc_v;
        e.rs1 = u1 ? w[19:15] : 5'd0;
        e.rs2 = u2 ? w[24:20] : 5'd0;
        e.rd = e.write_rd ? w[11:7] : 5'd0;
        if (!v) begin
            e = '0;
        end
        return e;
    endfunction

    // mostly x0..x3 so that hazards show up often
    function automatic logic [4:0] pick_reg();
        if ($urandom_range(0, 3) == 0) begin
            return 5'($urandom);
        end
        return 5'($urandom_range(0, 3));
    endfunction

    function automatic logic [31:0] random_instr(input int p_ill, input int p_load);
        logic [6:0] opc;
        logic [6:0] f7;
        if ($urandom_range(0, 99) < p_ill) begin
            return $urandom;
        end
        case ($urandom_range(0, 10))
            0:       opc = 7'h33;
            1:       opc = 7'h13;
            2:       opc = 7'h3b;
            3:       opc = 7'h1b;
            4:       opc = 7'h37;
            5:       opc = 7'h17;
            6:       opc = 7'h6f;
            7:       opc = 7'h67;
            8:       opc = 7'h63;
            9:       opc = 7'h03;
            default: opc = 7'h23;
        endcase
        if ($urandom_range(0, 99) < p_load) begin
            opc = 7'h03;
        end
        if ($urandom_range(0, 1) == 1) begin
            f7 = 7'($urandom);
        end else begin
            f7 = ($urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
        end
        return {f7, pick_reg(), pick_reg(), 3'($urandom), pick_reg(), opc};
    endfunction

    function automatic ex_ctrl_t dut_bundle();
        ex_ctrl_t a;
        a.valid = ex_valid;
        a.alu_op = ex_alu_op;
        a.sel_a = ex_sel_a;
        a.sel_b = ex_sel_b;
        a.wb_sel = ex_wb_sel;
        a.write_rd = ex_write_rd;
        a.mem_read = ex_mem_read;
        a.mem_write_mask = ex_mem_write_mask;
        a.load_size = ex_load_size;
        a.branch = ex_branch;
        a.jal = ex_jal;
        a.jalr = ex_jalr;
        a.illegal = ex_illegal;
        a.imm = ex_imm;
        a.pc = ex_pc;
        a.rs1 = ex_rs1;
        a.rs2 = ex_rs2;
        a.rd = ex_rd;
        return a;
    endfunction

    task automatic check_bundle(input string name, input ex_ctrl_t exp, input ex_ctrl_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("** Error [%s] ex bundle: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_stall(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("** Error [%s] id_stall: expected %b, actual %b", name, exp, act);
        end
    endtask

    // upstream keeps its instruction while id_stall is high
    task automatic next_inputs(input logic hold, input int p_ill, input int p_inv,
                               input int p_stall, input int p_flush, input int p_load);
        if (!hold) begin
            instr <= random_instr(p_ill, p_load);
            pc <= {$urandom, $urandom} & ~64'h3;
            instr_valid <= ($urandom_range(0, 99) >= p_inv);
        end
        stall <= ($urandom_range(0, 99) < p_stall);
        flush <= ($urandom_range(0, 99) < p_flush);
    endtask

    task automatic apply_reset();
        repeat (RESET_LEN) begin
            @(negedge clk);
            check_bundle("reset", '0, dut_bundle());
            check_stall("reset", 1'b0, id_stall);
            @(posedge clk);
            next_inputs(1'b0, 0, 0, 0, 0, 0);
        end
        rst_n <= 1'b1;
        test_count++;
        $display("test %-8s %0d cycles done, %0d errors", "reset", RESET_LEN, err_count);
    endtask

    task automatic run_cycle(input string name, input int p_ill, input int p_inv,
                             input int p_stall, input int p_flush, input int p_load);
        ex_ctrl_t d;
        logic     hz;
        @(negedge clk);
        d = model_decode(instr, pc, instr_valid);
        hz = ex_model.valid && ex_model.mem_read && ex_model.rd != 5'd0 && d.valid &&
             (d.rs1 == ex_model.rd || d.rs2 == ex_model.rd);
        check_bundle(name, ex_model, dut_bundle());
        check_stall(name, hz || stall, id_stall);
        if (flush) begin
            ex_model = '0;
        end else if (!stall) begin
            ex_model = hz ? '0 : d;
        end
        @(posedge clk);
        next_inputs(hz || stall, p_ill, p_inv, p_stall, p_flush, p_load);
    endtask

    task automatic run_test(input string name, input int n, input int p_ill, input int p_inv,
                            input int p_stall, input int p_flush, input int p_load);
        int errs_before;
        errs_before = err_count;
        repeat (n) run_cycle(name, p_ill, p_inv, p_stall, p_flush, p_load);
        test_count++;
        $display("test %-8s %0d cycles done, %0d errors", name, n, err_count - errs_before);
    endtask

    initial begin
        void'($urandom(32'h8b24));
        rst_n = 1'b0;
        instr = '0;
        pc = '0;
        instr_valid = 1'b0;
        flush = 1'b0;
        stall = 1'b0;
        ex_model = '0;
        err_count = 0;
        check_count = 0;
        test_count = 0;
        cycles = 0;
        apply_reset();
        run_test("decode", DECODE_LEN, 0, 0, 0, 0, 0);
        run_test("illegal", ILLEGAL_LEN, 40, 30, 0, 0, 0);
        run_test("loaduse", LOAD_LEN, 0, 5, 0, 0, 40);
        run_test("stall", STALL_LEN, 10, 10, 30, 0, 20);
        run_test("flush", FLUSH_LEN, 10, 10, 30, 20, 30);
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/ex_slice_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "ex_slice_cfg.svh"

module ex_slice_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [`ILEN-1:0]        instr_i,
    input  logic [`XLEN-1:0]        pc_i,
    input  logic                    instr_valid_i,
    input  logic                    flush_i,
    input  logic                    stall_i,
    output logic                    ex_valid_o,
    output ex_slice_pkg::alu_op_e   ex_alu_op_o,
    output ex_slice_pkg::sel_a_e    ex_sel_a_o,
    output ex_slice_pkg::sel_b_e    ex_sel_b_o,
    output ex_slice_pkg::wb_sel_e   ex_wb_sel_o,
    output logic                    ex_write_rd_o,
    output logic                    ex_mem_read_o,
    output logic [7:0]              ex_mem_write_mask_o,
    output logic [2:0]              ex_load_size_o,
    output logic                    ex_branch_o,
    output logic                    ex_jal_o,
    output logic                    ex_jalr_o,
    output logic                    ex_illegal_o,
    output logic [`XLEN-1:0]        ex_imm_o,
    output logic [`XLEN-1:0]        ex_pc_o,
    output logic [`RADDR_W-1:0]     ex_rs1_o,
    output logic [`RADDR_W-1:0]     ex_rs2_o,
    output logic [`RADDR_W-1:0]     ex_rd_o,
    output logic                    id_stall_o
);
    import ex_slice_pkg::*;

    ex_ctrl_t ex_q;     // bundle held in execute
    logic     nop_req;

    id_ctrl_if u_id_ctrl ();

    inst_decoder u_decoder (
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .instr_valid_i (instr_valid_i),
        .ctrl          (u_id_ctrl)
    );

    load_use_detector u_hazard (
        .dec        (u_id_ctrl),
        .ex_ctrl_i  (ex_q),
        .stall_i    (stall_i),
        .nop_req_o  (nop_req),
        .id_stall_o (id_stall_o)
    );

    id_ex_reg #(
        .PAYLOAD_T (ex_ctrl_t)
    ) u_id_ex (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .stall_i (stall_i),
        .nop_i   (nop_req),
        .d_i     (u_id_ctrl.bundle),
        .q_o     (ex_q)
    );

    assign ex_valid_o          = ex_q.valid;
    assign ex_alu_op_o         = ex_q.alu_op;
    assign ex_sel_a_o          = ex_q.sel_a;
    assign ex_sel_b_o          = ex_q.sel_b;
    assign ex_wb_sel_o         = ex_q.wb_sel;
    assign ex_write_rd_o       = ex_q.write_rd;
    assign ex_mem_read_o       = ex_q.mem_read;
    assign ex_mem_write_mask_o = ex_q.mem_write_mask;
    assign ex_load_size_o      = ex_q.load_size;
    assign ex_branch_o         = ex_q.branch;
    assign ex_jal_o            = ex_q.jal;
    assign ex_jalr_o           = ex_q.jalr;
    assign ex_illegal_o        = ex_q.illegal;
    assign ex_imm_o            = ex_q.imm;
    assign ex_pc_o             = ex_q.pc;
    assign ex_rs1_o            = ex_q.rs1;
    assign ex_rs2_o            = ex_q.rs2;
    assign ex_rd_o             = ex_q.rd;

endmodule

`default_nettype wire

//--- source/id_ex_reg.sv
`default_nettype none
`timescale 1ns/100ps

module id_ex_reg #(
    parameter type PAYLOAD_T = logic
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     flush_i,
    input  logic     stall_i,
    input  logic     nop_i,
    input  PAYLOAD_T d_i,
    output PAYLOAD_T q_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;     // wins over stall and nop
        end else if (stall_i) begin
            q_o <= q_o;
        end else if (nop_i) begin
            q_o <= '0;     // load-use bubble
        end else begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

//--- source/load_use_detector.sv
`default_nettype none
`timescale 1ns/100ps

module load_use_detector (
    id_ctrl_if.cons_mp           dec,
    input  ex_slice_pkg::ex_ctrl_t ex_ctrl_i,
    input  logic                 stall_i,
    output logic                 nop_req_o,
    output logic                 id_stall_o
);

    logic ex_is_load;
    logic rs1_hit;
    logic rs2_hit;
    logic hazard;

    // load in execute that really writes a register
    assign ex_is_load = ex_ctrl_i.valid && ex_ctrl_i.mem_read && (ex_ctrl_i.rd != '0);

    assign rs1_hit = dec.use_rs1 && (dec.bundle.rs1 == ex_ctrl_i.rd);
    assign rs2_hit = dec.use_rs2 && (dec.bundle.rs2 == ex_ctrl_i.rd);

    assign hazard = ex_is_load && dec.bundle.valid && (rs1_hit || rs2_hit);

    assign nop_req_o  = hazard;             // one bubble into execute
    assign id_stall_o = hazard || stall_i;  // upstream keeps the instruction

endmodule

`default_nettype wire

//--- source/inst_decoder.sv
`default_nettype none
`timescale 1ns/100ps

`include "ex_slice_cfg.svh"

module inst_decoder (
    input  logic [`ILEN-1:0] instr_i,
    input  logic [`XLEN-1:0] pc_i,
    input  logic             instr_valid_i,
    id_ctrl_if.dec_mp        ctrl
);
    import ex_slice_pkg::*;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    ex_ctrl_t         dec;
    logic             legal;
    logic             use_rs1;
    logic             use_rs2;

    // alt selects sub / sra
    function automatic alu_op_e base_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? ALU_SUB : ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return alt ? ALU_SRA : ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic alu_op_e word_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? ALU_SUBW : ALU_ADDW;
            3'd1:    return ALU_SLLW;
            default: return alt ? ALU_SRAW : ALU_SRLW;
        endcase
    endfunction

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{(`XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{(`XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {{(`XLEN-32){instr_i[31]}}, instr_i[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        dec     = '0;
        legal   = 1'b1;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            OPC_OP: begin
                legal        = (funct7 == 7'h00) ||
                               (funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5));
                use_rs1      = 1'b1;
                use_rs2      = 1'b1;
                dec.write_rd = 1'b1;
                dec.alu_op   = base_op(funct3, funct7[5]);
            end
            OPC_OP_IMM: begin
                legal = !((funct3 == 3'd1 && instr_i[31:26] != 6'b000000) ||
                          (funct3 == 3'd5 && instr_i[31:26] != 6'b000000 &&
                           instr_i[31:26] != 6'b010000));
                use_rs1      = 1'b1;
                dec.write_rd = 1'b1;
                dec.sel_b    = SEL_B_IMM;
                dec.imm      = imm_i;
                dec.alu_op   = base_op(funct3, funct3 == 3'd5 && instr_i[30]);
            end
            OPC_OP_32: begin
                legal = (funct7 == 7'h00 && (funct3 == 3'd0 || funct3 == 3'd1 ||
                                             funct3 == 3'd5)) ||
                        (funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5));
                use_rs1      = 1'b1;
                use_rs2      = 1'b1;
                dec.write_rd = 1'b1;
                dec.alu_op   = word_op(funct3, funct7[5]);
            end
            OPC_OP_IMM_32: begin
                legal = (funct3 == 3'd0) || (funct3 == 3'd1 && funct7 == 7'h00) ||
                        (funct3 == 3'd5 && (funct7 == 7'h00 || funct7 == 7'h20));
                use_rs1      = 1'b1;
                dec.write_rd = 1'b1;
                dec.sel_b    = SEL_B_IMM;
                dec.imm      = imm_i;
                dec.alu_op   = word_op(funct3, funct3 != 3'd0 && funct7[5]);
            end
            OPC_LUI: begin
                dec.write_rd = 1'b1;
                dec.alu_op   = ALU_PASS_B;
                dec.sel_a    = SEL_A_ZERO;
                dec.sel_b    = SEL_B_IMM;
                dec.imm      = imm_u;
            end
            OPC_AUIPC: begin
                dec.write_rd = 1'b1;
                dec.sel_a    = SEL_A_PC;
                dec.sel_b    = SEL_B_IMM;
                dec.imm      = imm_u;
            end
            OPC_JAL: begin
                dec.write_rd = 1'b1;
                dec.jal      = 1'b1;
                dec.sel_a    = SEL_A_PC;   // link value pc+4
                dec.sel_b    = SEL_B_FOUR;
                dec.wb_sel   = WB_PC4;
                dec.imm      = imm_j;
            end
            OPC_JALR: begin
                legal        = (funct3 == 3'd0);
                use_rs1      = 1'b1;
                dec.write_rd = 1'b1;
                dec.jalr     = 1'b1;
                dec.sel_a    = SEL_A_PC;
                dec.sel_b    = SEL_B_FOUR;
                dec.wb_sel   = WB_PC4;
                dec.imm      = imm_i;
            end
            OPC_BRANCH: begin
                legal      = (funct3 != 3'd2 && funct3 != 3'd3);
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
                dec.branch = 1'b1;
                dec.imm    = imm_b;
                dec.alu_op = funct3[2] ? (funct3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
            end
            OPC_LOAD: begin
                legal         = (funct3 != 3'd7);
                use_rs1       = 1'b1;
                dec.write_rd  = 1'b1;
                dec.mem_read  = 1'b1;
                dec.wb_sel    = WB_MEM;
                dec.sel_b     = SEL_B_IMM;
                dec.imm       = imm_i;
                dec.load_size = funct3;
            end
            OPC_STORE: begin
                legal     = !funct3[2];
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                dec.sel_b = SEL_B_IMM;
                dec.imm   = imm_s;
                case (funct3[1:0])
                    2'd0:    dec.mem_write_mask = 8'h01;
                    2'd1:    dec.mem_write_mask = 8'h03;
                    2'd2:    dec.mem_write_mask = 8'h0f;
                    default: dec.mem_write_mask = 8'hff;
                endcase
            end
            default: legal = 1'b0;   // system, csr, fence, ...
        endcase

        if (!legal) begin
            dec         = '0;
            use_rs1     = 1'b0;
            use_rs2     = 1'b0;
            dec.illegal = 1'b1;
        end
        dec.valid = 1'b1;
        dec.pc    = pc_i;
        dec.rs1   = use_rs1 ? instr_i[19:15] : '0;
        dec.rs2   = use_rs2 ? instr_i[24:20] : '0;
        dec.rd    = dec.write_rd ? instr_i[11:7] : '0;

        if (!instr_valid_i) begin
            dec     = '0;
            use_rs1 = 1'b0;
            use_rs2 = 1'b0;
        end
    end

    assign ctrl.bundle  = dec;
    assign ctrl.use_rs1 = use_rs1;
    assign ctrl.use_rs2 = use_rs2;

endmodule

`default_nettype wire

//--- source/id_ctrl_if.sv
`default_nettype none
`timescale 1ns/100ps

interface id_ctrl_if;
    import ex_slice_pkg::*;

    ex_ctrl_t bundle;   // decoded execute fields
    logic     use_rs1;  // rs1 is a live source
    logic     use_rs2;

    modport dec_mp (
        output bundle,
        output use_rs1,
        output use_rs2
    );

    modport cons_mp (
        input bundle,
        input use_rs1,
        input use_rs2
    );

endinterface

`default_nettype wire

//--- source/ex_slice_pkg.sv
`default_nettype none

`include "ex_slice_cfg.svh"

package ex_slice_pkg;

    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_SLL    = 5'd2,
        ALU_SLT    = 5'd3,
        ALU_SLTU   = 5'd4,
        ALU_XOR    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_OR     = 5'd8,
        ALU_AND    = 5'd9,
        ALU_ADDW   = 5'd10,
        ALU_SUBW   = 5'd11,
        ALU_SLLW   = 5'd12,
        ALU_SRLW   = 5'd13,
        ALU_SRAW   = 5'd14,
        ALU_PASS_B = 5'd15   // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_A_RS1  = 2'd0,
        SEL_A_PC   = 2'd1,
        SEL_A_ZERO = 2'd2
    } sel_a_e;

    typedef enum logic [1:0] {
        SEL_B_RS2  = 2'd0,
        SEL_B_IMM  = 2'd1,
        SEL_B_FOUR = 2'd2
    } sel_b_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

    // all zero is a bubble
    typedef struct packed {
        logic                valid;
        alu_op_e             alu_op;
        sel_a_e              sel_a;
        sel_b_e              sel_b;
        wb_sel_e             wb_sel;
        logic                write_rd;
        logic                mem_read;
        logic [7:0]          mem_write_mask;
        logic [2:0]          load_size;      // funct3 of the load
        logic                branch;
        logic                jal;
        logic                jalr;
        logic                illegal;
        logic [`XLEN-1:0]    imm;
        logic [`XLEN-1:0]    pc;
        logic [`RADDR_W-1:0] rs1;
        logic [`RADDR_W-1:0] rs2;
        logic [`RADDR_W-1:0] rd;
    } ex_ctrl_t;

endpackage

`default_nettype wire

//--- source/ex_slice_cfg.svh
`ifndef EX_SLICE_CFG_SVH
`define EX_SLICE_CFG_SVH

// datapath width of the RV64I core
`define XLEN 64

// fixed-length base encoding without compressed
`define ILEN 32

// x0..x31
`define RADDR_W 5

`endif
